/* design/dct_pkg.sv */
package dct_pkg;

    typedef logic signed [15:0] coef_t;
    typedef logic signed [15:0] sample_t;
    typedef logic signed [31:0] acc_t;

    localparam int PROD_SHIFT = 8;  // coefficients carry a 4096 scale

    // c[k][j] with k the input column of s' and j the output column of T
    localparam coef_t DCT_C [8][8] = '{
        '{1448,  2008,  1892,  1702,  1448,  1137,   783,   399},
        '{1448,  1702,   783,  -399, -1448, -2008, -1892, -1137},
        '{1448,  1137,  -783, -2008, -1448,   399,  1892,  1702},
        '{1448,   399, -1892, -1137,  1448,  1702,  -783, -2008},
        '{1448,  -399, -1892,  1137,  1448, -1702,  -783,  2008},
        '{1448, -1137,  -783,  2008, -1448,  -399,  1892, -1702},
        '{1448, -1702,   783,   399, -1448,  2008, -1892,  1137},
        '{1448, -2008,  1892, -1702,  1448, -1137,   783,  -399}
    };

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_WAIT_BANK,   // bank not filled yet
        XF_MAC,
        XF_EMIT
    } xform_state_e;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_WAIT_BANK,   // bank still held by the transform
        FE_READ,
        FE_DRAIN        // reads issued, words still in flight
    } fetch_state_e;

endpackage

/* design/sram_map_pkg.sv */
package sram_map_pkg;

    typedef logic [17:0] sram_addr_t;
    typedef logic [15:0] sram_data_t;

    localparam int BLOCK_DIM = 8;
    localparam int BLOCK_SIZE = 64;
    localparam int SRAM_READ_LATENCY = 2;   // cycles from address on the pins to data

    typedef logic [6:0] buf_addr_t;  // bank bit, then 6-bit index inside the block

    // word address of pixel (prow, pcol), row times width built from shifted rows
    function automatic sram_addr_t pixel_addr(input int unsigned width,
                                              input sram_addr_t prow,
                                              input sram_addr_t pcol);
        sram_addr_t addr;
        addr = pcol;
        for (int b = 0; b < $bits(sram_addr_t); b++) begin
            if (width[b])
                addr = addr + (prow << b);
        end
        return addr;
    endfunction

endpackage

/* design/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter import sram_map_pkg::*; (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       rd_req,
    input  sram_addr_t rd_addr,
    input  logic       wr_req,
    input  sram_addr_t wr_addr,
    input  sram_data_t wr_data,
    output logic       rd_gnt,
    output sram_addr_t sram_address,
    output sram_data_t sram_write_data,
    output logic       sram_we_n
);

    // writeback always wins, a denied read simply waits
    assign rd_gnt = rd_req && !wr_req;

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            sram_address <= '0;
            sram_we_n <= 1'b1;
        end else begin
            sram_we_n <= !wr_req;   // low only for the granted write
            if (wr_req)
                sram_address <= wr_addr;
            else if (rd_req)
                sram_address <= rd_addr;
            // no request keeps the last address on the pins
        end
    end

    always_ff @(posedge CLOCK) begin
        if (wr_req)
            sram_write_data <= wr_data;
    end

endmodule

/* design/block_fetch.sv */
`timescale 1ns/1ps

module block_fetch import sram_map_pkg::*, dct_pkg::*; #(
    parameter int BLOCK_COLS = 40,
    parameter int BLOCK_ROWS = 30
) (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       start,
    input  logic       rd_gnt,
    input  sram_data_t sram_read_data,
    input  logic [1:0] bank_full,
    output logic       rd_req,
    output sram_addr_t rd_addr,
    output logic       buf_we,
    output buf_addr_t  buf_waddr,
    output sram_data_t buf_wdata,
    output logic       fill_done,
    output logic       fill_bank
);

    localparam int WIDTH = BLOCK_COLS * BLOCK_DIM;
    localparam int COL_W = $clog2(BLOCK_COLS + 1);
    localparam int ROW_W = $clog2(BLOCK_ROWS + 1);

    fetch_state_e state;
    logic [COL_W-1:0] blk_col;
    logic [ROW_W-1:0] blk_row;
    logic [5:0] m;          // ri in [5:3], ci in [2:0]
    logic bank;
    logic [SRAM_READ_LATENCY:0] vld_pipe;   // one stage for the arbiter register
    buf_addr_t tag_pipe [SRAM_READ_LATENCY+1];

    assign rd_req = (state == FE_READ);
    assign rd_addr = pixel_addr(WIDTH, sram_addr_t'({blk_row, m[5:3]}),
                                sram_addr_t'({blk_col, m[2:0]}));

    // returning word goes to the index tagged when its read was granted
    assign buf_we = vld_pipe[SRAM_READ_LATENCY];
    assign buf_waddr = tag_pipe[SRAM_READ_LATENCY];
    assign buf_wdata = sram_read_data;
    assign fill_done = buf_we && (buf_waddr[5:0] == 6'(BLOCK_SIZE - 1));
    assign fill_bank = buf_waddr[6];

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            state <= FE_IDLE;
            blk_col <= '0;
            blk_row <= '0;
            m <= '0;
            bank <= 1'b0;
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[SRAM_READ_LATENCY-1:0], rd_gnt};
            case (state)
                FE_IDLE: begin
                    if (start) begin
                        blk_col <= '0;
                        blk_row <= '0;
                        m <= '0;
                        bank <= 1'b0;
                        state <= FE_WAIT_BANK;
                    end
                end
                FE_WAIT_BANK: begin
                    if (!bank_full[bank])
                        state <= FE_READ;
                end
                FE_READ: begin
                    if (rd_gnt) begin
                        m <= m + 6'd1;
                        if (m == 6'(BLOCK_SIZE - 1)) begin  // last read of the block
                            bank <= !bank;
                            state <= FE_DRAIN;
                            if (blk_col == COL_W'(BLOCK_COLS - 1)) begin
                                blk_col <= '0;
                                if (blk_row == ROW_W'(BLOCK_ROWS - 1))
                                    blk_row <= '0;
                                else
                                    blk_row <= blk_row + 1'b1;
                            end else begin
                                blk_col <= blk_col + 1'b1;
                            end
                        end
                    end
                end
                FE_DRAIN: begin
                    // counters back at 0,0 means the picture has wrapped
                    if (fill_done)
                        state <= (blk_col == '0 && blk_row == '0) ? FE_IDLE : FE_WAIT_BANK;
                end
                default: state <= FE_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK) begin
        tag_pipe[0] <= {bank, m};
        for (int i = 1; i <= SRAM_READ_LATENCY; i++)
            tag_pipe[i] <= tag_pipe[i-1];
    end

endmodule

/* design/block_buffer.sv */
`timescale 1ns/1ps

module block_buffer import sram_map_pkg::*, dct_pkg::*; (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       buf_we,
    input  buf_addr_t  buf_waddr,
    input  sram_data_t buf_wdata,
    input  logic       fill_done,
    input  logic       fill_bank,
    input  buf_addr_t  rd_index,
    input  logic       bank_release,
    input  logic       release_bank,
    output sample_t    rd_data,
    output logic [1:0] bank_full
);

    sample_t mem [2*BLOCK_SIZE];    // two blocks of s'
    logic [1:0] full;

    assign bank_full = full;

    always_ff @(posedge CLOCK) begin
        if (buf_we)
            mem[buf_waddr] <= $signed(buf_wdata);
        rd_data <= mem[rd_index];   // data one cycle after the index
    end

    // a bank belongs to fetch while clear and to the transform while set
    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            full <= '0;
        end else begin
            if (fill_done)
                full[fill_bank] <= 1'b1;
            if (bank_release)
                full[release_bank] <= 1'b0;
        end
    end

endmodule

/* design/row_transform.sv */
`timescale 1ns/1ps

module row_transform import dct_pkg::*, sram_map_pkg::*; #(
    parameter int BLOCK_COLS = 40,
    parameter int BLOCK_ROWS = 30
) (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       start,
    input  logic [1:0] bank_full,
    input  sample_t    rd_data,
    output buf_addr_t  rd_index,
    output logic       t_valid,
    output acc_t       t_value,
    output logic [5:0] t_index,
    output logic       bank_release,
    output logic       release_bank
);

    localparam int TOTAL = BLOCK_COLS * BLOCK_ROWS;
    localparam int CNT_W = $clog2(TOTAL + 1);

    xform_state_e state;
    logic [5:0] out_idx;    // r in [5:3], j in [2:0]
    logic [2:0] k;
    logic [2:0] k_data;
    logic bank;
    logic [CNT_W-1:0] blk_cnt;
    acc_t acc;
    acc_t prod;
    acc_t term;

    assign rd_index = {bank, out_idx[5:3], k};

    // rd_data answers the index of the previous cycle
    // k has wrapped to 0 in XF_EMIT so this gives 7 there
    assign k_data = k - 3'd1;
    assign prod = rd_data * DCT_C[k_data][out_idx[2:0]];
    assign term = prod >>> PROD_SHIFT;

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            state <= XF_IDLE;
            out_idx <= '0;
            k <= '0;
            bank <= 1'b0;
            blk_cnt <= '0;
            acc <= '0;
            t_valid <= 1'b0;
            bank_release <= 1'b0;
            release_bank <= 1'b0;
        end else begin
            t_valid <= 1'b0;
            bank_release <= 1'b0;
            case (state)
                XF_IDLE: begin
                    if (start) begin
                        out_idx <= '0;
                        k <= '0;
                        bank <= 1'b0;
                        blk_cnt <= '0;
                        acc <= '0;
                        state <= XF_WAIT_BANK;
                    end
                end
                XF_WAIT_BANK: begin
                    if (bank_full[bank])
                        state <= XF_MAC;
                end
                XF_MAC: begin
                    if (k != 3'd0)
                        acc <= acc + term;  // first cycle only issues the read
                    k <= k + 3'd1;
                    if (k == 3'd7)
                        state <= XF_EMIT;
                end
                XF_EMIT: begin
                    t_valid <= 1'b1;
                    acc <= '0;              // fresh sum for the next output
                    out_idx <= out_idx + 6'd1;
                    if (out_idx == 6'(BLOCK_SIZE - 1)) begin
                        bank_release <= 1'b1;
                        release_bank <= bank;
                        bank <= !bank;
                        blk_cnt <= blk_cnt + 1'b1;
                        if (blk_cnt == CNT_W'(TOTAL - 1))
                            state <= XF_IDLE;
                        else
                            state <= XF_WAIT_BANK;
                    end else begin
                        state <= XF_MAC;
                    end
                end
                default: state <= XF_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK) begin
        if (state == XF_EMIT) begin
            t_value <= acc + term;  // adds the k = 7 term
            t_index <= out_idx;
        end
    end

endmodule

/* design/t_writeback.sv */
`timescale 1ns/1ps

module t_writeback import dct_pkg::*, sram_map_pkg::*; #(
    parameter int BLOCK_COLS = 40,
    parameter int BLOCK_ROWS = 30,
    parameter int RESULT_BASE = 76800
) (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       start,
    input  logic       t_valid,
    input  acc_t       t_value,
    input  logic [5:0] t_index,
    output logic       wr_req,
    output sram_addr_t wr_addr,
    output sram_data_t wr_data,
    output logic       busy,
    output logic       done
);

    localparam int WIDTH = BLOCK_COLS * BLOCK_DIM;
    localparam int COL_W = $clog2(BLOCK_COLS + 1);
    localparam int ROW_W = $clog2(BLOCK_ROWS + 1);

    logic [COL_W-1:0] blk_col;
    logic [ROW_W-1:0] blk_row;
    logic last_blk;
    logic blk_end;
    logic last_wr;      // the write now on wr_req closes the picture
    sram_data_t clamped;

    assign last_blk = (blk_col == COL_W'(BLOCK_COLS - 1)) && (blk_row == ROW_W'(BLOCK_ROWS - 1));
    assign blk_end = t_valid && (t_index == 6'(BLOCK_SIZE - 1));

    // saturate to the signed 16-bit range
    always_comb begin
        if (t_value > 32'sd32767)
            clamped = 16'h7fff;
        else if (t_value < -32'sd32768)
            clamped = 16'h8000;
        else
            clamped = t_value[15:0];
    end

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            wr_req <= 1'b0;
            last_wr <= 1'b0;
            done <= 1'b0;
            busy <= 1'b0;
            blk_col <= '0;
            blk_row <= '0;
        end else begin
            wr_req <= t_valid;
            last_wr <= blk_end && last_blk;
            done <= last_wr;
            if (start) begin
                busy <= 1'b1;
                blk_col <= '0;
                blk_row <= '0;
            end else begin
                if (last_wr)
                    busy <= 1'b0;   // drops together with done
                if (blk_end) begin
                    if (blk_col == COL_W'(BLOCK_COLS - 1)) begin
                        blk_col <= '0;
                        blk_row <= (blk_row == ROW_W'(BLOCK_ROWS - 1)) ? '0 : blk_row + 1'b1;
                    end else begin
                        blk_col <= blk_col + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK) begin
        if (t_valid) begin
            wr_data <= clamped;
            wr_addr <= sram_addr_t'(RESULT_BASE)
                     + pixel_addr(WIDTH, sram_addr_t'({blk_row, t_index[5:3]}),
                                  sram_addr_t'({blk_col, t_index[2:0]}));
        end
    end

endmodule

/* design/idct_stage1_top.sv */
`timescale 1ns/1ps

module idct_stage1_top import sram_map_pkg::*, dct_pkg::*; #(
    parameter int BLOCK_COLS = 40,
    parameter int BLOCK_ROWS = 30,
    parameter int RESULT_BASE = 76800
) (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       start,
    input  sram_data_t sram_read_data,
    output sram_addr_t sram_address,
    output sram_data_t sram_write_data,
    output logic       sram_we_n,
    output logic       busy,
    output logic       done
);

    logic       start_go;
    logic       rd_req;
    logic       rd_gnt;
    sram_addr_t rd_addr;
    logic       wr_req;
    sram_addr_t wr_addr;
    sram_data_t wr_data;
    logic       buf_we;
    buf_addr_t  buf_waddr;
    sram_data_t buf_wdata;
    logic       fill_done;
    logic       fill_bank;
    logic [1:0] bank_full;
    buf_addr_t  rd_index;
    sample_t    rd_data;
    logic       t_valid;
    acc_t       t_value;
    logic [5:0] t_index;
    logic       bank_release;
    logic       release_bank;

    assign start_go = start && !busy;   // a start during a run is dropped

    block_fetch #(
        .BLOCK_COLS (BLOCK_COLS),
        .BLOCK_ROWS (BLOCK_ROWS)
    ) u_block_fetch (
        .CLOCK          (CLOCK),
        .Resetn         (Resetn),
        .start          (start_go),
        .rd_gnt         (rd_gnt),
        .sram_read_data (sram_read_data),
        .bank_full      (bank_full),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .buf_we         (buf_we),
        .buf_waddr      (buf_waddr),
        .buf_wdata      (buf_wdata),
        .fill_done      (fill_done),
        .fill_bank      (fill_bank)
    );

    block_buffer u_block_buffer (
        .CLOCK        (CLOCK),
        .Resetn       (Resetn),
        .buf_we       (buf_we),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata),
        .fill_done    (fill_done),
        .fill_bank    (fill_bank),
        .rd_index     (rd_index),
        .bank_release (bank_release),
        .release_bank (release_bank),
        .rd_data      (rd_data),
        .bank_full    (bank_full)
    );

    row_transform #(
        .BLOCK_COLS (BLOCK_COLS),
        .BLOCK_ROWS (BLOCK_ROWS)
    ) u_row_transform (
        .CLOCK        (CLOCK),
        .Resetn       (Resetn),
        .start        (start_go),
        .bank_full    (bank_full),
        .rd_data      (rd_data),
        .rd_index     (rd_index),
        .t_valid      (t_valid),
        .t_value      (t_value),
        .t_index      (t_index),
        .bank_release (bank_release),
        .release_bank (release_bank)
    );

    t_writeback #(
        .BLOCK_COLS  (BLOCK_COLS),
        .BLOCK_ROWS  (BLOCK_ROWS),
        .RESULT_BASE (RESULT_BASE)
    ) u_t_writeback (
        .CLOCK   (CLOCK),
        .Resetn  (Resetn),
        .start   (start_go),
        .t_valid (t_valid),
        .t_value (t_value),
        .t_index (t_index),
        .wr_req  (wr_req),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .busy    (busy),
        .done    (done)
    );

    sram_arbiter u_sram_arbiter (
        .CLOCK           (CLOCK),
        .Resetn          (Resetn),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .wr_req          (wr_req),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_gnt          (rd_gnt),
        .sram_address    (sram_address),
        .sram_write_data (sram_write_data),
        .sram_we_n       (sram_we_n)
    );

endmodule

/* sim/idct_stage1_sva.sv */
`timescale 1ns/1ps

module idct_stage1_sva import sram_map_pkg::*; #(
    parameter int RESULT_BASE = 76800
) (
    input logic       CLOCK,
    input logic       Resetn,
    input sram_addr_t sram_address,
    input logic       sram_we_n,
    input logic       done
);

    // write strobe parked while reset is held
    a_we_n_in_reset: assert property (@(posedge CLOCK) !Resetn |-> sram_we_n)
        else $error("sram_we_n low while Resetn is low");

    a_done_pulse: assert property (@(posedge CLOCK) disable iff (!Resetn)
                                   done |=> !done)
        else $error("done high for two cycles in a row");

    // results never land in the input picture
    a_write_region: assert property (@(posedge CLOCK) disable iff (!Resetn)
                                     !sram_we_n |-> int'(sram_address) >= RESULT_BASE)
        else $error("write below the result base");

endmodule

bind idct_stage1_top idct_stage1_sva #(
    .RESULT_BASE (RESULT_BASE)
) u_idct_stage1_sva (
    .CLOCK        (CLOCK),
    .Resetn       (Resetn),
    .sram_address (sram_address),
    .sram_we_n    (sram_we_n),
    .done         (done)
);

/* sim/tb_idct_stage1.sv */
`timescale 1ns/1ps

module tb_idct_stage1 import sram_map_pkg::*, dct_pkg::*; ();

    localparam int BLOCK_COLS = 2;
    localparam int BLOCK_ROWS = 1;
    localparam int RESULT_BASE = 1024;
    localparam int WIDTH = BLOCK_COLS * BLOCK_DIM;
    localparam int NUM_WORDS = BLOCK_COLS * BLOCK_ROWS * BLOCK_SIZE;
    localparam int MEM_AW = 11;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int TIMEOUT_CYCLES = 2 * 2 * 1000;  // runs x blocks x cycles per block
    localparam int SETTLE_CYCLES = 20;

    logic       CLOCK;
    logic       Resetn;
    logic       start;
    sram_data_t sram_read_data;
    sram_addr_t sram_address;
    sram_data_t sram_write_data;
    logic       sram_we_n;
    logic       busy;
    logic       done;

    logic [15:0] sram_mem [MEM_WORDS];
    logic [15:0] cases_mem [2*NUM_WORDS];
    logic [15:0] src [NUM_WORDS];       // block-major s' of the current run
    logic [15:0] expect_t [NUM_WORDS];
    sram_data_t  rd_q1;
    sram_data_t  rd_q2;
    int cycle_cnt = 0;
    int write_cnt = 0;
    int done_cnt = 0;
    int monitor_errs = 0;
    int value_errs = 0;
    int other_errs = 0;
    integer seed;

    idct_stage1_top #(
        .BLOCK_COLS  (BLOCK_COLS),
        .BLOCK_ROWS  (BLOCK_ROWS),
        .RESULT_BASE (RESULT_BASE)
    ) u_idct_stage1_top (
        .CLOCK           (CLOCK),
        .Resetn          (Resetn),
        .start           (start),
        .sram_read_data  (sram_read_data),
        .sram_address    (sram_address),
        .sram_write_data (sram_write_data),
        .sram_we_n       (sram_we_n),
        .busy            (busy),
        .done            (done)
    );

    initial begin
        CLOCK = 1'b0;
        forever #10 CLOCK = ~CLOCK;
    end

    // sram model with data for the address of cycle n on the pins in cycle n+2
    always @(posedge CLOCK) begin
        cycle_cnt <= cycle_cnt + 1;
        rd_q1 <= sram_mem[sram_address[MEM_AW-1:0]];
        rd_q2 <= rd_q1;
        if (!sram_we_n)
            sram_mem[sram_address[MEM_AW-1:0]] = sram_write_data;
    end

    initial begin
        sram_read_data = '0;
        forever @(negedge CLOCK) sram_read_data <= rd_q2;
    end

    // port monitor sampled mid-cycle
    always @(negedge CLOCK) begin
        if (Resetn && !sram_we_n) begin
            write_cnt = write_cnt + 1;
            if (int'(sram_address) < RESULT_BASE
                || int'(sram_address) >= RESULT_BASE + NUM_WORDS) begin
                $display("write to address %h outside the result region", sram_address);
                monitor_errs = monitor_errs + 1;
            end
        end
        if (Resetn && done) begin
            done_cnt = done_cnt + 1;
            if (busy !== 1'b0) begin
                $display("FAIL busy got %h expected %h while done is high", busy, 1'b0);
                monitor_errs = monitor_errs + 1;
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES)
            @(posedge CLOCK);
        $display("timeout after %0d cycles without the run finishing", cycle_cnt);
        $display("Something failed");
        $finish;
    end

    // picture word offset of entry idx of a block-major list
    function automatic int pic_offset(input int idx);
        int blk;
        int r;
        int c;
        blk = idx / BLOCK_SIZE;
        r = (idx / BLOCK_DIM) % BLOCK_DIM;
        c = idx % BLOCK_DIM;
        return ((blk / BLOCK_COLS) * BLOCK_DIM + r) * WIDTH + (blk % BLOCK_COLS) * BLOCK_DIM + c;
    endfunction

    // one T entry as the saturated sum of shifted products
    function automatic logic [15:0] compute_t(input int idx);
        int base;
        int j;
        int sum;
        acc_t prod;
        j = idx % BLOCK_DIM;
        base = idx - j;
        sum = 0;
        for (int k = 0; k < BLOCK_DIM; k++) begin
            prod = 32'($signed(src[base + k])) * 32'(DCT_C[k][j]);
            sum = sum + (prod >>> PROD_SHIFT);
        end
        if (sum > 32767)
            return 16'h7fff;
        else if (sum < -32768)
            return 16'h8000;
        return 16'(sum);
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < MEM_WORDS; a++)
            sram_mem[a] = 16'(a * 5) ^ 16'hc3a5;
    endtask

    task automatic load_inputs();
        for (int i = 0; i < NUM_WORDS; i++)
            sram_mem[pic_offset(i)] = src[i];
    endtask

    task automatic check_results();
        int a;
        for (int i = 0; i < NUM_WORDS; i++) begin
            a = pic_offset(i);
            if (sram_mem[RESULT_BASE + a] !== expect_t[i]) begin
                $display("FAIL sram[%h] got %h expected %h",
                         11'(RESULT_BASE + a), sram_mem[RESULT_BASE + a], expect_t[i]);
                value_errs = value_errs + 1;
            end
            if (sram_mem[a] !== src[i]) begin
                $display("FAIL sram[%h] got %h expected %h", 11'(a), sram_mem[a], src[i]);
                value_errs = value_errs + 1;
            end
        end
    endtask

    task automatic run_picture(input logic extra_start);
        int writes_before;
        int dones_before;
        writes_before = write_cnt;
        dones_before = done_cnt;
        @(negedge CLOCK);
        if (busy !== 1'b0) begin
            $display("FAIL busy got %h expected %h before start", busy, 1'b0);
            other_errs = other_errs + 1;
        end
        start = 1'b1;
        @(negedge CLOCK);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("FAIL busy got %h expected %h after start", busy, 1'b1);
            other_errs = other_errs + 1;
        end
        if (extra_start) begin
            // a restart here would send the second block's results to the first block
            while (write_cnt - writes_before < BLOCK_SIZE + BLOCK_DIM)
                @(negedge CLOCK);
            start = 1'b1;
            @(negedge CLOCK);
            start = 1'b0;
        end
        while (!done)
            @(negedge CLOCK);
        repeat (SETTLE_CYCLES) @(negedge CLOCK);
        if (busy !== 1'b0) begin
            $display("FAIL busy got %h expected %h after done", busy, 1'b0);
            other_errs = other_errs + 1;
        end
        if (done_cnt - dones_before != 1) begin
            $display("done pulsed %0d times in one run", done_cnt - dones_before);
            other_errs = other_errs + 1;
        end
        if (write_cnt - writes_before != NUM_WORDS) begin
            $display("%0d writes in one run instead of %0d",
                     write_cnt - writes_before, NUM_WORDS);
            other_errs = other_errs + 1;
        end
        check_results();
    endtask

    initial begin
        int r;
        Resetn = 1'b1;
        start = 1'b0;
        seed = 32'h4140;
        $readmemh("sim/idct_stage1_cases.txt", cases_mem);
        for (int i = 0; i < NUM_WORDS; i++) begin
            src[i] = cases_mem[i];
            expect_t[i] = cases_mem[NUM_WORDS + i];
        end
        fill_memory();
        load_inputs();

        #1 Resetn = 1'b0;
        repeat (4) @(posedge CLOCK);
        @(negedge CLOCK);
        if (busy !== 1'b0) begin
            $display("FAIL busy got %h expected %h in reset", busy, 1'b0);
            other_errs = other_errs + 1;
        end
        if (done !== 1'b0) begin
            $display("FAIL done got %h expected %h in reset", done, 1'b0);
            other_errs = other_errs + 1;
        end
        if (sram_we_n !== 1'b1) begin
            $display("FAIL sram_we_n got %h expected %h in reset", sram_we_n, 1'b1);
            other_errs = other_errs + 1;
        end
        Resetn = 1'b1;

        run_picture(1'b0);          // picture from the cases file

        fill_memory();              // clears the old results too
        for (int i = 0; i < NUM_WORDS; i++) begin
            r = $random(seed) % 2049;
            src[i] = 16'(r);
        end
        for (int i = 0; i < NUM_WORDS; i++)
            expect_t[i] = compute_t(i);
        load_inputs();
        run_picture(1'b1);

        $display("errors: %0d value, %0d control, %0d monitor",
                 value_errs, other_errs, monitor_errs);
        if (value_errs == 0 && other_errs == 0 && monitor_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim/idct_stage1_cases.txt */
// s' input rows: lines 1-16 hold block 0 rows 0-7 then block 1 rows 0-7, columns k = 0..7
// expected T rows: lines 17-32 in the same block and row order, columns j = 0..7
0100 0000 0000 0000 0000 0000 0000 0000
0000 0100 0000 0000 0000 0000 0000 0000
0000 0000 0100 0000 0000 0000 0000 0000
0000 0000 0000 0100 0000 0000 0000 0000
0000 0000 0000 0000 ff00 0000 0000 0000
0000 0000 0000 0000 0000 ff00 0000 0000
0000 0000 0000 0000 0000 0000 0100 0000
0000 0000 0000 0000 0000 0000 0000 0100
0100 0100 0100 0100 0100 0100 0100 0100
0000 0001 0000 0000 0000 0000 0000 0000
7fff 0000 0000 0000 0000 0000 0000 0000
8000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0080 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0200
0000 0000 0000 0000 0000 0000 0000 0000
0100 0000 0000 0000 0000 0000 0000 0100
05a8 07d8 0764 06a6 05a8 0471 030f 018f
05a8 06a6 030f fe71 fa58 f828 f89c fb8f
05a8 0471 fcf1 f828 fa58 018f 0764 06a6
05a8 018f f89c fb8f 05a8 06a6 fcf1 f828
fa58 018f 0764 fb8f fa58 06a6 030f f828
fa58 0471 030f f828 05a8 018f f89c 06a6
05a8 f95a 030f 018f fa58 07d8 f89c 0471
05a8 f828 0764 f95a 05a8 fb8f 030f fe71
2d40 0000 0000 0000 0000 0000 0000 0000
0005 0006 0003 fffe fffa fff8 fff8 fffb
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
8000 8000 8000 8000 8000 8000 8000 8000
02d4 00c7 fc4e fdc7 02d4 0353 fe78 fc14
0b50 f050 0ec8 f2b4 0b50 f71e 061e fce2
0000 0000 0000 0000 0000 0000 0000 0000
0b50 0000 0ec8 0000 0b50 0000 061e 0000

/* idct_stage1.f */
design/dct_pkg.sv
design/sram_map_pkg.sv
design/sram_arbiter.sv
design/block_fetch.sv
design/block_buffer.sv
design/row_transform.sv
design/t_writeback.sv
design/idct_stage1_top.sv
sim/idct_stage1_sva.sv
sim/tb_idct_stage1.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_idct_stage1
FILELIST   ?= idct_stage1.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
